/* source/itim_params.svh */
`ifndef ITIM_PARAMS_SVH
`define ITIM_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// itim geometry.
// ~~~~~~~~~~~~~~~~~~~~

`define ITIM_DEPTH 64 // rows per bank.
`define ITIM_WIDTH 4 // banks, words per line.

`define ITIM_SET_BITS ($clog2(`ITIM_DEPTH))
`define ITIM_WORD_BITS ($clog2(`ITIM_WIDTH))

// ~~~~~~~~~~~~~~~~~~~~
// cacheable window, top is exclusive.
// ~~~~~~~~~~~~~~~~~~~~

`define ITIM_BASE_ADDR 32'h0000_1000
`define ITIM_TOP_ADDR 32'h0000_2000

`endif

/* source/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

  // fetch and memory bus widths.
  localparam int addr_bits = 32;
  localparam int data_bits = 32;

  // byte offset inside one word.
  localparam int byte_bits = $clog2(data_bits / 8);

  // byte address.
  typedef logic [addr_bits-1:0] addr_t;

  // instruction word.
  typedef logic [data_bits-1:0] word_t;

endpackage

`default_nettype wire

/* source/itim_pkg.sv */
`default_nettype none

`include "itim_params.svh"

package itim_pkg;

  import mem_bus_pkg::*;

  // address split, low to high: byte, word, set, tag.
  localparam int word_lsb = byte_bits;
  localparam int set_lsb = word_lsb + `ITIM_WORD_BITS;
  localparam int tag_lsb = set_lsb + `ITIM_SET_BITS;
  localparam int tag_bits = addr_bits - tag_lsb;

  // one ram row holds valid, tag and data.
  localparam int ram_word_bits = 1 + tag_bits + data_bits;

  typedef logic [`ITIM_SET_BITS-1:0] set_index_t;
  typedef logic [`ITIM_WORD_BITS-1:0] word_index_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [ram_word_bits-1:0] ram_word_t;

  typedef enum logic [1:0] {
    lookup,
    fill,
    pass,
    sweep
  } itim_state_t;

endpackage

`default_nettype wire

/* source/itim_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itim_params.svh"

module itim_ram
  import itim_pkg::*;
(
  input logic clock,
  input logic wen,
  input set_index_t waddr,
  input set_index_t raddr,
  input ram_word_t wdata,
  output ram_word_t rdata
);

  ram_word_t ram_array [`ITIM_DEPTH] = '{default: '0}; // all rows start invalid.

  set_index_t raddr_q;

  always_ff @(posedge clock) begin
    raddr_q <= raddr;
    if (wen) begin
      ram_array[waddr] <= wdata;
    end
  end

  // read lands one cycle after the address.
  assign rdata = ram_array[raddr_q];

endmodule

`default_nettype wire

/* source/itim_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itim_params.svh"

module itim_ctrl
  import mem_bus_pkg::*, itim_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input addr_t req_addr,
  output logic resp_ready,
  output word_t resp_rdata,
  output logic mem_valid,
  output addr_t mem_addr,
  input logic mem_ready,
  input word_t mem_rdata,
  output logic [`ITIM_WIDTH-1:0] bank_wen,
  output set_index_t bank_waddr [`ITIM_WIDTH],
  output set_index_t bank_raddr [`ITIM_WIDTH],
  output ram_word_t bank_wdata [`ITIM_WIDTH],
  input ram_word_t bank_rdata [`ITIM_WIDTH]
);

  itim_state_t state;
  itim_state_t state_next;

  logic f_valid;
  logic f_fence;
  addr_t f_addr;
  tag_t f_tag;
  set_index_t f_set;
  word_index_t f_word;
  set_index_t req_set;

  addr_t b_addr;
  tag_t b_tag;
  set_index_t b_set;
  word_index_t b_word;
  set_index_t sweep_row;

  ram_word_t sel_word;
  logic sel_valid;
  tag_t sel_tag;
  word_t sel_data;
  logic in_window;

  logic lk_hit;
  logic lk_fill;
  logic lk_pass;
  logic lk_sweep;

  logic fill_req;
  logic pass_req;
  logic mem_done;
  logic fill_done;
  logic sweeping;
  logic sweep_last;

  tag_t cur_tag;
  set_index_t cur_set;
  word_index_t cur_word;

  // ~~~~~~~~~~~~~~~~~~~~
  // front stage
  // ~~~~~~~~~~~~~~~~~~~~

  // read launched with the request, held otherwise.
  assign req_set = req_valid ? req_addr[set_lsb +: `ITIM_SET_BITS] : f_set;

  always_ff @(posedge clock) begin
    if (!reset) begin
      f_valid <= 1'b0;
    end else begin
      f_valid <= req_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      f_fence <= req_fence;
      f_addr <= req_addr;
      f_tag <= req_addr[tag_lsb +: tag_bits];
      f_set <= req_addr[set_lsb +: `ITIM_SET_BITS];
      f_word <= req_addr[word_lsb +: `ITIM_WORD_BITS];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // lookup
  // ~~~~~~~~~~~~~~~~~~~~

  assign sel_word = bank_rdata[f_word];
  assign sel_valid = sel_word[ram_word_bits-1];
  assign sel_tag = sel_word[data_bits +: tag_bits];
  assign sel_data = sel_word[data_bits-1:0];
  assign in_window = (f_addr >= `ITIM_BASE_ADDR) && (f_addr < `ITIM_TOP_ADDR);

  always_comb begin
    lk_hit = 1'b0;
    lk_fill = 1'b0;
    lk_pass = 1'b0;
    lk_sweep = 1'b0;
    if ((state == lookup) && f_valid) begin
      if (f_fence) begin
        lk_sweep = 1'b1;
      end else if (!in_window) begin
        lk_pass = 1'b1;
      end else if (!sel_valid) begin
        lk_fill = 1'b1;
      end else if (sel_tag != f_tag) begin
        lk_pass = 1'b1; // conflict, no replacement.
      end else begin
        lk_hit = 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // back stage
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (state == lookup) begin
      b_addr <= f_addr;
      b_tag <= f_tag;
      b_set <= f_set;
      b_word <= f_word;
    end
  end

  // lookup cycle works off the front registers.
  assign cur_tag = (state == lookup) ? f_tag : b_tag;
  assign cur_set = (state == lookup) ? f_set : b_set;
  assign cur_word = (state == lookup) ? f_word : b_word;

  assign fill_req = (state == lookup) ? lk_fill : (state == fill);
  assign pass_req = (state == lookup) ? lk_pass : (state == pass);
  assign mem_done = mem_valid && mem_ready;
  assign fill_done = mem_done && fill_req;
  assign sweeping = (state == sweep);
  assign sweep_last = sweeping && (sweep_row == '1);

  assign mem_valid = fill_req || pass_req;
  assign mem_addr = (state == lookup) ? f_addr : b_addr;

  assign resp_ready = lk_hit || mem_done || sweep_last;
  assign resp_rdata = lk_hit ? sel_data : mem_rdata;

  always_comb begin
    state_next = state;
    unique case (state)
      lookup: begin
        if (lk_sweep) begin
          state_next = sweep;
        end else if (lk_fill && !mem_ready) begin
          state_next = fill;
        end else if (lk_pass && !mem_ready) begin
          state_next = pass;
        end
      end
      fill, pass: begin
        if (mem_ready) begin
          state_next = lookup;
        end
      end
      sweep: begin
        if (sweep_row == '1) begin
          state_next = lookup;
        end
      end
      default: state_next = lookup;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= lookup;
      sweep_row <= '0;
    end else begin
      state <= state_next;
      if (lk_sweep) begin
        sweep_row <= '0;
      end else if (sweeping) begin
        sweep_row <= sweep_row + 1'b1;
      end
    end
  end

  // sweep clears a row in every bank, a fill writes one bank.
  always_comb begin
    for (int i = 0; i < `ITIM_WIDTH; i++) begin
      bank_raddr[i] = req_set;
      bank_waddr[i] = sweeping ? sweep_row : cur_set;
      bank_wen[i] = sweeping || (fill_done && (cur_word == word_index_t'(i)));
      bank_wdata[i] = sweeping ? '0 : {1'b1, cur_tag, mem_rdata};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~

  // request held through a memory stall.
  a_mem_hold : assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr));

  // fetch side keeps to one request at a time.
  a_one_outstanding : assert property (@(posedge clock) disable iff (!reset)
    $rose(req_valid) |-> (state == lookup));

endmodule

`default_nettype wire

/* source/itim.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itim_params.svh"

module itim
  import mem_bus_pkg::*, itim_pkg::*;
#(
  parameter int itim_enable = 1
)
(
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input addr_t req_addr,
  output logic resp_ready,
  output word_t resp_rdata,
  output logic mem_valid,
  output addr_t mem_addr,
  input logic mem_ready,
  input word_t mem_rdata
);

  generate
    if (itim_enable == 1) begin : g_itim

      logic [`ITIM_WIDTH-1:0] bank_wen;
      set_index_t bank_waddr [`ITIM_WIDTH];
      set_index_t bank_raddr [`ITIM_WIDTH];
      ram_word_t bank_wdata [`ITIM_WIDTH];
      ram_word_t bank_rdata [`ITIM_WIDTH];

      // one bank per word of a line.
      for (genvar i = 0; i < `ITIM_WIDTH; i++) begin : g_bank
        itim_ram u_ram (
          .clock (clock),
          .wen (bank_wen[i]),
          .waddr (bank_waddr[i]),
          .raddr (bank_raddr[i]),
          .wdata (bank_wdata[i]),
          .rdata (bank_rdata[i])
        );
      end

      itim_ctrl u_ctrl (
        .clock (clock),
        .reset (reset),
        .req_valid (req_valid),
        .req_fence (req_fence),
        .req_addr (req_addr),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .mem_valid (mem_valid),
        .mem_addr (mem_addr),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .bank_wen (bank_wen),
        .bank_waddr (bank_waddr),
        .bank_raddr (bank_raddr),
        .bank_wdata (bank_wdata),
        .bank_rdata (bank_rdata)
      );

    end else begin : g_bypass

      // fetch goes straight to memory.
      assign mem_valid = req_valid;
      assign mem_addr = req_addr;
      assign resp_ready = mem_ready;
      assign resp_rdata = mem_rdata;

    end
  endgenerate

endmodule

`default_nettype wire

/* testbench/imem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module imem_model
  import mem_bus_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input addr_t mem_addr,
  output logic mem_ready,
  output word_t mem_rdata,
  output logic [31:0] request_count
);

  logic [31:0] rand_state;
  logic busy;
  logic [2:0] wait_left;
  logic [2:0] delay;

  function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  assign delay = 3'(rand_state % 32'd6); // 0 to 5 stall cycles.

  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    request_count = '0;
    rand_state = 32'hb19323b5;
    busy = 1'b0;
    wait_left = '0;
  end

  always @(posedge clock) begin
    if (!reset) begin
      mem_ready <= 1'b0;
      busy <= 1'b0;
      request_count <= '0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0; // transfer completes on this edge.
      busy <= 1'b0;
    end else if (busy) begin
      if (wait_left == 3'd0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem_addr ^ 32'h5a5a_0000;
      end else begin
        wait_left <= wait_left - 3'd1;
      end
    end else if (mem_valid) begin
      request_count <= request_count + 32'd1;
      rand_state <= xorshift32(rand_state);
      if (delay == 3'd0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem_addr ^ 32'h5a5a_0000;
      end else begin
        busy <= 1'b1;
        wait_left <= delay - 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/itim_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itim_params.svh"

module itim_tb
  import mem_bus_pkg::*;
();

  localparam int timeout_cycles = 200;

  logic clock = 1'b0;
  logic reset;
  logic req_valid;
  logic req_fence;
  addr_t req_addr;
  logic resp_ready;
  word_t resp_rdata;
  logic mem_valid;
  addr_t mem_addr;
  logic mem_ready;
  word_t mem_rdata;
  logic [31:0] request_count;

  int error_count = 0;
  int test_count = 0;
  int failed_tests = 0;
  int test_errors = 0;
  int fetch_cycles = 0; // edges after the request edge.
  word_t fetch_data;
  logic [31:0] rand_state = 32'hb19323b5;

  always #5 clock = ~clock;

  itim #(.itim_enable(1)) u_itim (
    .clock (clock),
    .reset (reset),
    .req_valid (req_valid),
    .req_fence (req_fence),
    .req_addr (req_addr),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .mem_valid (mem_valid),
    .mem_addr (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  imem_model u_imem (
    .clock (clock),
    .reset (reset),
    .mem_valid (mem_valid),
    .mem_addr (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .request_count (request_count)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic word_t rule_word(input addr_t addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
      input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - test_errors);
    end
  endtask

  // one request pulse, then wait for resp_ready.
  task automatic fetch(input addr_t addr, input logic fence);
    logic done;
    done = 1'b0;
    fetch_cycles = 0;
    @(posedge clock);
    req_valid <= 1'b1;
    req_fence <= fence;
    req_addr <= addr;
    @(posedge clock);
    req_valid <= 1'b0;
    req_fence <= 1'b0;
    while (!done && fetch_cycles < timeout_cycles) begin
      @(posedge clock);
      fetch_cycles++;
      if (resp_ready) begin
        done = 1'b1;
        fetch_data = resp_rdata;
      end
    end
    if (!done) begin
      $display("Timeout at %0t: no response to the request for address %h", $time, addr);
      error_count++;
    end
  endtask

  task automatic fetch_word(input addr_t addr, input int new_requests);
    logic [31:0] count_before;
    count_before = request_count;
    fetch(addr, 1'b0);
    check_value("resp_rdata", fetch_data, rule_word(addr));
    check_value("request_count", request_count - count_before, 32'(new_requests));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_state();
    test_errors = error_count;
    repeat (3) begin
      @(posedge clock);
      check_value("resp_ready", 32'(resp_ready), 32'd0);
      check_value("mem_valid", 32'(mem_valid), 32'd0);
    end
    finish_test("reset_state");
  endtask

  task automatic test_window_hit();
    test_errors = error_count;
    fetch_word(32'h0000_1100, 1); // first touch fills.
    fetch_word(32'h0000_1100, 0);
    check_value("hit_latency", 32'(fetch_cycles), 32'd1);
    finish_test("window_hit");
  endtask

  task automatic test_outside_window();
    test_errors = error_count;
    fetch_word(32'h0000_0040, 1);
    fetch_word(32'h0000_0040, 1);
    fetch_word(32'h8000_0010, 1);
    fetch_word(32'h8000_0010, 1);
    finish_test("outside_window");
  endtask

  task automatic test_tag_conflict();
    test_errors = error_count;
    fetch_word(32'h0000_1234, 1);
    fetch_word(32'h0000_1634, 1); // same set and word, next tag.
    fetch_word(32'h0000_1634, 1);
    fetch_word(32'h0000_1234, 0);
    check_value("hit_latency", 32'(fetch_cycles), 32'd1);
    finish_test("tag_conflict");
  endtask

  task automatic test_fence();
    logic [31:0] count_before;
    test_errors = error_count;
    count_before = request_count;
    fetch(32'h0000_0000, 1'b1);
    check_value("fence_latency", 32'(fetch_cycles), 32'(`ITIM_DEPTH + 1));
    check_value("request_count", request_count - count_before, 32'd0);
    fetch_word(32'h0000_1100, 1); // stored before, gone now.
    fetch_word(32'h0000_1100, 0);
    finish_test("fence");
  endtask

  task automatic test_random_sequence();
    logic table_valid [`ITIM_DEPTH][`ITIM_WIDTH];
    logic [31:0] table_tag [`ITIM_DEPTH][`ITIM_WIDTH];
    logic [31:0] count_before;
    logic [31:0] tag;
    addr_t addr;
    int set_index;
    int word_index;
    int new_requests;
    int expected_requests;
    test_errors = error_count;
    table_valid = '{default: 1'b0};
    expected_requests = 0;
    fetch(32'h0000_0000, 1'b1); // start from an empty ITIM.
    count_before = request_count;
    for (int i = 0; i < 40; i++) begin
      rand_state = xorshift32(rand_state);
      // four tags, two sets, four words, so conflicts are common.
      addr = `ITIM_BASE_ADDR + (32'(rand_state[9:8]) << 10) + (32'(rand_state[4]) << 4)
        + (32'(rand_state[1:0]) << 2);
      word_index = int'((addr >> 2) % `ITIM_WIDTH);
      set_index = int'((addr >> (2 + `ITIM_WORD_BITS)) % `ITIM_DEPTH);
      tag = addr >> (2 + `ITIM_WORD_BITS + `ITIM_SET_BITS);
      new_requests = 1;
      if (!table_valid[set_index][word_index]) begin
        table_valid[set_index][word_index] = 1'b1;
        table_tag[set_index][word_index] = tag;
      end else if (table_tag[set_index][word_index] == tag) begin
        new_requests = 0;
      end
      expected_requests += new_requests;
      fetch_word(addr, new_requests);
    end
    check_value("total_requests", request_count - count_before, 32'(expected_requests));
    finish_test("random_sequence");
  endtask

  initial begin
    reset = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr = '0;
    repeat (8) @(posedge clock);
    reset <= 1'b1;
    test_reset_state();
    test_window_hit();
    test_outside_window();
    test_tag_conflict();
    test_fence();
    test_random_sequence();
    $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/mem_bus_pkg.sv
source/itim_pkg.sv
source/itim_ram.sv
source/itim_ctrl.sv
source/itim.sv
testbench/imem_model.sv
testbench/itim_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ITIM testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module itim_tb -o itim_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/itim_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$log_file"; then
  exit 1
fi
exit 0
